// File: list.f
+incdir+include
rtl/uart_pkg.sv
rtl/uart_fifo.sv
rtl/uart_baud_gen.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_system.sv
rtl/sim_top.sv
tests/uart_assertions.sv
tests/tb_sim_top.sv

// File: Bender.yml
package:
  name: sim_uart

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/uart_pkg.sv
      - rtl/uart_fifo.sv
      - rtl/uart_baud_gen.sv
      - rtl/uart_tx.sv
      - rtl/uart_rx.sv
      - rtl/uart_system.sv
      - rtl/sim_top.sv

  - target: simulation
    include_dirs:
      - include
    files:
      - tests/uart_assertions.sv
      - tests/tb_sim_top.sv

// File: tests/tb_sim_top.sv
/*
 * tb_sim_top: testbench playing host and virtual UART, with a
 * transmit line monitor, a watchdog and the final report
 */

`timescale 1ns/1ps
`default_nettype none

`include "uart_defines.svh"

module tb_sim_top;

  localparam int bit_cycles   = 32;
  localparam int frame_cycles = 10 * bit_cycles;
  localparam int depth        = `UART_FIFO_DEPTH;
  // Plain bytes, burst, received frames and the overrun run
  localparam int total_frames    = 3 + (depth + 2) + 4 + (depth + 1);
  localparam int watchdog_cycles = total_frames * frame_cycles + 2000;

  logic                   clk;
  logic                   rst;
  logic                   tx_wr;
  uart_pkg::uart_byte_t   tx_data;
  logic                   rx_rd;
  uart_pkg::rx_entry_t    rx_entry;
  uart_pkg::uart_status_t status;
  logic                   uart_rx;
  logic                   uart_tx;

  logic [7:0]             lfsr_q;
  uart_pkg::uart_byte_t   tx_exp [$];
  uart_pkg::rx_entry_t    rx_exp [$];
  int                     value_errs;
  int                     other_errs;

  sim_top dut (
    .clk_i      (clk),
    .rst_i      (rst),
    .tx_wr_i    (tx_wr),
    .tx_data_i  (tx_data),
    .rx_rd_i    (rx_rd),
    .rx_entry_o (rx_entry),
    .status_o   (status),
    .uart_rx_i  (uart_rx),
    .uart_tx_o  (uart_tx)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Fibonacci LFSR x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];
    lfsr_q = {lfsr_q[6:0], fb};
    return fb;
  endfunction

  function automatic uart_pkg::uart_byte_t rand_byte();
    uart_pkg::uart_byte_t b;
    for (int i = 0; i < 8; i++) begin
      b[i] = lfsr_bit();
    end
    return b;
  endfunction

  task automatic flag_mismatch(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    value_errs++;
  endtask

  task automatic report_failure(input string msg);
    $display("Failure at %0t ns: %s", $time, msg);
    other_errs++;
  endtask

  // One write per cycle and the byte is expected only if the FIFO had room
  task automatic write_bytes(input int n, output int dropped);
    uart_pkg::uart_byte_t b;
    dropped = 0;
    for (int i = 0; i < n; i++) begin
      b = rand_byte();
      tx_wr = 1'b1;
      tx_data = b;
      if (status.tx_full) begin
        dropped++;
      end else begin
        tx_exp.push_back(b);
      end
      @(negedge clk);
    end
    tx_wr = 1'b0;
  endtask

  task automatic wait_tx_idle(input int max_cycles);
    int n;
    n = 0;
    while (status.tx_busy && n < max_cycles) begin
      @(negedge clk);
      n++;
    end
    if (status.tx_busy) begin
      report_failure("transmitter still busy after the queued frames");
    end
  endtask

  // Virtual UART sends an 8N1 frame with a chosen stop level
  task automatic send_frame(input uart_pkg::uart_byte_t data, input logic stop_level);
    uart_rx = 1'b0;
    repeat (bit_cycles) @(negedge clk);
    for (int i = 0; i < 8; i++) begin
      uart_rx = data[i];
      repeat (bit_cycles) @(negedge clk);
    end
    uart_rx = stop_level;
    repeat (bit_cycles) @(negedge clk);
    uart_rx = 1'b1;
  endtask

  task automatic read_expect();
    uart_pkg::rx_entry_t exp_e;
    int n;
    n = 0;
    while (!status.rx_valid && n < 2 * bit_cycles) begin
      @(negedge clk);
      n++;
    end
    if (!status.rx_valid) begin
      report_failure("no received entry showed up within two bit times");
    end else if (rx_exp.size() == 0) begin
      flag_mismatch($sformatf("unexpected rx entry %02h", rx_entry.data));
    end else begin
      exp_e = rx_exp.pop_front();
      assert (rx_entry == exp_e) else flag_mismatch($sformatf(
        "rx entry %02h ferr %0b, expected %02h ferr %0b",
        rx_entry.data, rx_entry.frame_err, exp_e.data, exp_e.frame_err));
      rx_rd = 1'b1;
      @(negedge clk);
      rx_rd = 1'b0;
    end
  endtask

  // Decodes uart_tx_o at mid-bit and compares against the write order
  initial begin : tx_monitor
    uart_pkg::uart_byte_t got;
    uart_pkg::uart_byte_t exp_b;
    @(negedge rst);
    forever begin
      @(negedge clk);
      if (!uart_tx) begin
        repeat (bit_cycles / 2) @(negedge clk);
        assert (!uart_tx) else flag_mismatch("start bit gone before mid-bit");
        for (int i = 0; i < 8; i++) begin
          repeat (bit_cycles) @(negedge clk);
          got[i] = uart_tx;
        end
        repeat (bit_cycles) @(negedge clk);
        assert (uart_tx) else flag_mismatch("stop bit low on uart_tx_o");
        if (tx_exp.size() == 0) begin
          flag_mismatch($sformatf("unexpected byte %02h on uart_tx_o", got));
        end else begin
          exp_b = tx_exp.pop_front();
          assert (got == exp_b) else flag_mismatch(
            $sformatf("tx byte %02h, expected %02h", got, exp_b));
        end
      end
    end
  end

  initial begin : watchdog
    repeat (watchdog_cycles) @(posedge clk);
    $display("Timeout: run did not finish within %0d clock cycles", watchdog_cycles);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin : main_seq
    int                   dropped;
    int                   total;
    uart_pkg::rx_entry_t  e;
    lfsr_q = 8'd94;
    value_errs = 0;
    other_errs = 0;
    rst = 1'b1;
    tx_wr = 1'b0;
    tx_data = '0;
    rx_rd = 1'b0;
    uart_rx = 1'b1;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    assert (uart_tx && status == '0) else flag_mismatch("line or status wrong after reset");

    // Three bytes that all fit
    write_bytes(3, dropped);
    assert (dropped == 0) else flag_mismatch("write dropped with room in the FIFO");
    wait_tx_idle(4 * frame_cycles);
    assert (tx_exp.size() == 0) else flag_mismatch("queued bytes never sent");

    // Burst past the FIFO depth while one byte leaves for the transmitter
    write_bytes(depth + 2, dropped);
    assert (dropped == 1) else flag_mismatch(
      $sformatf("%0d writes dropped during the burst, expected 1", dropped));
    wait_tx_idle((depth + 3) * frame_cycles);
    assert (tx_exp.size() == 0) else flag_mismatch("accepted burst bytes never sent");

    // Received frames with a low stop bit on the last
    for (int i = 0; i < 4; i++) begin
      e.data = rand_byte();
      e.frame_err = (i == 3);
      rx_exp.push_back(e);
      send_frame(e.data, !e.frame_err);
      read_expect();
      repeat (bit_cycles) @(negedge clk);
    end

    // One frame more than the FIFO holds and no reads
    for (int i = 0; i <= depth; i++) begin
      e.data = rand_byte();
      e.frame_err = 1'b0;
      if (i < depth) begin
        rx_exp.push_back(e);
      end
      send_frame(e.data, 1'b1);
    end
    assert (status.rx_overrun) else flag_mismatch("rx_overrun not set");
    repeat (depth) read_expect();
    assert (status.rx_overrun && !status.rx_valid)
      else flag_mismatch("overrun cleared or extra entry after reads");

    repeat (4) @(negedge clk);
    total = value_errs + other_errs + int'(dut.u_uart_sva.fail_count);
    $display("Errors: %0d value, %0d other, %0d assertion",
             value_errs, other_errs, dut.u_uart_sva.fail_count);
    if (total == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/uart_assertions.sv
/*
 * uart_assertions: concurrent checks bound to sim_top for the serial line,
 * the reset state, writes while full and the sticky overrun flag
 */

`timescale 1ns/1ps
`default_nettype none

`include "uart_defines.svh"

module uart_assertions (
  input logic                                         clk_i,
  input logic                                         rst_i,
  input logic                                         tx_wr_i,
  input uart_pkg::uart_status_t                       status_i,
  input logic                                         txd_i,
  input logic                                         tx_pop_i,
  input logic [$clog2(`UART_FIFO_DEPTH + 1)-1:0]      tx_count_i
);

  // Number of assertion failures so far
  int unsigned fail_count = 0;

  // Line idle high and all flags low on the cycle after a reset cycle
  a_reset_state: assert property (@(posedge clk_i)
    rst_i |=> (txd_i && status_i == '0))
    else begin
      $error("line or status not at reset values after reset");
      fail_count++;
    end

  // A write into a full transmit FIFO leaves its count alone
  a_full_write: assert property (@(posedge clk_i) disable iff (rst_i)
    (tx_wr_i && status_i.tx_full && !tx_pop_i) |=> (tx_count_i == $past(tx_count_i)))
    else begin
      $error("write while tx_full changed the transmit FIFO count");
      fail_count++;
    end

  // Overrun only clears through reset
  a_overrun_sticky: assert property (@(posedge clk_i)
    (status_i.rx_overrun && !rst_i) |=> status_i.rx_overrun)
    else begin
      $error("rx_overrun fell without reset");
      fail_count++;
    end

  // Start bit lasts 16 ticks of 2 cycles
  a_start_bit: assert property (@(posedge clk_i) disable iff (rst_i)
    tx_pop_i |=> !txd_i [*32])
    else begin
      $error("start bit not held low for 32 cycles");
      fail_count++;
    end

endmodule

bind sim_top uart_assertions u_uart_sva (
  .clk_i      (clk_i),
  .rst_i      (rst_i),
  .tx_wr_i    (tx_wr_i),
  .status_i   (status_o),
  .txd_i      (uart_tx_o),
  .tx_pop_i   (u_uart_system.tx_pop),
  .tx_count_i (u_uart_system.u_tx_fifo.count_q)
);

`default_nettype wire

// File: rtl/sim_top.sv
/*
 * sim_top: simulation top level joining the UART block
 * to the host ports and the serial pins of the virtual device
 */

`timescale 1ns/1ps
`default_nettype none

module sim_top (
  input  logic                   clk_i,
  input  logic                   rst_i,
  // Host side
  input  logic                   tx_wr_i,
  input  uart_pkg::uart_byte_t   tx_data_i,
  input  logic                   rx_rd_i,
  output uart_pkg::rx_entry_t    rx_entry_o,
  output uart_pkg::uart_status_t status_o,
  // Serial pins, far end is the virtual UART
  input  logic                   uart_rx_i,
  output logic                   uart_tx_o
);

  // System UART, pins wired straight through with no added latency
  uart_system u_uart_system (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .tx_wr_i    (tx_wr_i),
    .tx_data_i  (tx_data_i),
    .rx_rd_i    (rx_rd_i),
    .rxd_i      (uart_rx_i),
    .rx_entry_o (rx_entry_o),
    .status_o   (status_o),
    .txd_o      (uart_tx_o)
  );

endmodule

`default_nettype wire

// File: rtl/uart_system.sv
/*
 * uart_system: baud generator, transmit and receive FIFOs,
 * transmitter, receiver and the sticky overrun flag
 */

`timescale 1ns/1ps
`default_nettype none

`include "uart_defines.svh"

module uart_system (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   tx_wr_i,
  input  uart_pkg::uart_byte_t   tx_data_i,
  input  logic                   rx_rd_i,
  input  logic                   rxd_i,
  output uart_pkg::rx_entry_t    rx_entry_o,
  output uart_pkg::uart_status_t status_o,
  output logic                   txd_o
);

  logic                 tick;
  uart_pkg::uart_byte_t tx_head;
  logic                 tx_empty;
  logic                 tx_full;
  logic                 tx_pop;
  logic                 tx_busy;
  logic                 rx_push;
  uart_pkg::rx_entry_t  rx_entry;
  logic                 rx_empty;
  logic                 rx_full;
  logic                 rx_overrun_q;

  uart_baud_gen u_baud_gen (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .tick_o (tick)
  );

  uart_fifo #(
    .entry_t (uart_pkg::uart_byte_t),
    .DEPTH   (`UART_FIFO_DEPTH)
  ) u_tx_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (tx_wr_i),
    .data_i  (tx_data_i),
    .pop_i   (tx_pop),
    .data_o  (tx_head),
    .empty_o (tx_empty),
    .full_o  (tx_full)
  );

  uart_tx u_tx (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .tick_i  (tick),
    .start_i (!tx_empty),
    .data_i  (tx_head),
    .pop_o   (tx_pop),
    .busy_o  (tx_busy),
    .txd_o   (txd_o)
  );

  uart_rx u_rx (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .tick_i  (tick),
    .rxd_i   (rxd_i),
    .push_o  (rx_push),
    .entry_o (rx_entry)
  );

  uart_fifo #(
    .entry_t (uart_pkg::rx_entry_t),
    .DEPTH   (`UART_FIFO_DEPTH)
  ) u_rx_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (rx_push),
    .data_i  (rx_entry),
    .pop_i   (rx_rd_i),
    .data_o  (rx_entry_o),
    .empty_o (rx_empty),
    .full_o  (rx_full)
  );

  // A byte arriving at a full receive FIFO is lost, flag stays until reset
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rx_overrun_q <= 1'b0;
    end else if (rx_push && rx_full) begin
      rx_overrun_q <= 1'b1;
    end
  end

  always_comb begin
    status_o.tx_full    = tx_full;
    status_o.tx_busy    = tx_busy || !tx_empty;
    status_o.rx_valid   = !rx_empty;
    status_o.rx_overrun = rx_overrun_q;
  end

endmodule

`default_nettype wire

// File: rtl/uart_rx.sv
/*
 * uart_rx: 8N1 deserializer with a two-flop line synchronizer,
 * mid-bit sampling and stop-bit frame check
 */

`timescale 1ns/1ps
`default_nettype none

module uart_rx (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                tick_i,
  input  logic                rxd_i,
  output logic                push_o,
  output uart_pkg::rx_entry_t entry_o
);

  typedef enum logic [1:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_stop
  } rx_state_e;

  rx_state_e            state_q;
  logic [1:0]           sync_q;
  logic                 rxd_prev_q;
  logic                 rxd_s;
  logic [3:0]           os_cnt_q;
  logic [2:0]           bit_idx_q;
  uart_pkg::uart_byte_t shift_q;
  logic                 push_q;
  uart_pkg::rx_entry_t  entry_q;

  assign rxd_s   = sync_q[1];
  assign push_o  = push_q;
  assign entry_o = entry_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync_q     <= 2'b11;
      rxd_prev_q <= 1'b1;
      state_q    <= rx_idle;
      os_cnt_q   <= '0;
      bit_idx_q  <= '0;
      push_q     <= 1'b0;
    end else begin
      sync_q     <= {sync_q[0], rxd_i};
      rxd_prev_q <= rxd_s;
      push_q     <= 1'b0;
      case (state_q)
        rx_idle: begin
          os_cnt_q <= '0;
          // Falling edge marks a possible start bit
          if (rxd_prev_q && !rxd_s) state_q <= rx_start;
        end
        rx_start: begin
          if (tick_i) begin
            if (os_cnt_q == 4'd7) begin
              // Middle of the start bit, high again means a glitch
              os_cnt_q  <= '0;
              bit_idx_q <= '0;
              state_q   <= rxd_s ? rx_idle : rx_data;
            end else begin
              os_cnt_q <= os_cnt_q + 4'd1;
            end
          end
        end
        rx_data: begin
          if (tick_i) begin
            os_cnt_q <= os_cnt_q + 4'd1;
            if (os_cnt_q == 4'd15) begin
              bit_idx_q <= bit_idx_q + 3'd1;
              if (bit_idx_q == 3'd7) state_q <= rx_stop;
            end
          end
        end
        default: begin
          if (tick_i) begin
            os_cnt_q <= os_cnt_q + 4'd1;
            if (os_cnt_q == 4'd15) begin
              push_q  <= 1'b1;
              state_q <= rx_idle;
            end
          end
        end
      endcase
    end
  end

  // Payload path, sampled at mid-bit
  always_ff @(posedge clk_i) begin
    if (tick_i && os_cnt_q == 4'd15) begin
      if (state_q == rx_data) begin
        shift_q <= {rxd_s, shift_q[7:1]};
      end
      if (state_q == rx_stop) begin
        entry_q.data      <= shift_q;
        entry_q.frame_err <= !rxd_s;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/uart_tx.sv
/*
 * uart_tx: 8N1 serializer, start bit, data LSB first, stop bit,
 * each held for 16 oversample ticks
 */

`timescale 1ns/1ps
`default_nettype none

module uart_tx (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 tick_i,
  input  logic                 start_i,
  input  uart_pkg::uart_byte_t data_i,
  output logic                 pop_o,
  output logic                 busy_o,
  output logic                 txd_o
);

  typedef enum logic [1:0] {
    tx_idle,
    tx_start,
    tx_data,
    tx_stop
  } tx_state_e;

  tx_state_e            state_q;
  logic [3:0]           os_cnt_q;
  logic [2:0]           bit_idx_q;
  uart_pkg::uart_byte_t shift_q;
  logic                 bit_end;

  // Last tick of the current bit
  assign bit_end = tick_i && (os_cnt_q == 4'd15);

  // Frames only begin on a tick so every bit lasts exactly 16 ticks
  assign pop_o = start_i &&
                 ((state_q == tx_idle && tick_i) || (state_q == tx_stop && bit_end));

  assign busy_o = (state_q != tx_idle);

  always_comb begin
    case (state_q)
      tx_start: txd_o = 1'b0;
      tx_data:  txd_o = shift_q[0];
      default:  txd_o = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= tx_idle;
      os_cnt_q  <= '0;
      bit_idx_q <= '0;
    end else begin
      // Counter wraps to zero at the end of each bit
      if (tick_i && state_q != tx_idle) os_cnt_q <= os_cnt_q + 4'd1;
      case (state_q)
        tx_idle: begin
          if (pop_o) state_q <= tx_start;
        end
        tx_start: begin
          if (bit_end) begin
            state_q   <= tx_data;
            bit_idx_q <= '0;
          end
        end
        tx_data: begin
          if (bit_end) begin
            bit_idx_q <= bit_idx_q + 3'd1;
            if (bit_idx_q == 3'd7) state_q <= tx_stop;
          end
        end
        default: begin
          // Queued byte follows straight on, no idle bits
          if (bit_end) state_q <= pop_o ? tx_start : tx_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      shift_q <= data_i;
    end else if (state_q == tx_data && bit_end) begin
      shift_q <= {1'b0, shift_q[7:1]};
    end
  end

endmodule

`default_nettype wire

// File: rtl/uart_baud_gen.sv
/*
 * uart_baud_gen: divider producing a one-cycle tick
 * at the oversampled baud rate
 */

`timescale 1ns/1ps
`default_nettype none

`include "uart_defines.svh"

module uart_baud_gen (
  input  logic clk_i,
  input  logic rst_i,
  output logic tick_o
);

  // Clock cycles per oversample tick
  localparam int baud_div = `UART_CLK_FREQ / (`UART_BAUD_RATE * `UART_OVERSAMPLE);
  localparam int cnt_w    = (baud_div > 1) ? $clog2(baud_div) : 1;

  logic [cnt_w-1:0] cnt_q;

  // Counts down and reloads, ticking once per reload
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q  <= '0;
      tick_o <= 1'b0;
    end else if (cnt_q == '0) begin
      cnt_q  <= cnt_w'(baud_div - 1);
      tick_o <= 1'b1;
    end else begin
      cnt_q  <= cnt_q - cnt_w'(1);
      tick_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: rtl/uart_fifo.sv
/*
 * uart_fifo: synchronous circular-buffer FIFO with a type
 * parameter for the payload, head entry shown on data_o
 */

`timescale 1ns/1ps
`default_nettype none

module uart_fifo #(
  parameter type entry_t = logic [7:0],
  parameter int  DEPTH   = 4
) (
  input  logic   clk_i,
  input  logic   rst_i,
  input  logic   push_i,
  input  entry_t data_i,
  input  logic   pop_i,
  output entry_t data_o,
  output logic   empty_o,
  output logic   full_o
);

  localparam int ptr_w = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int cnt_w = $clog2(DEPTH + 1);

  entry_t           mem_q [DEPTH];
  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [cnt_w-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  // Pointers wrap at DEPTH, which need not be a power of two
  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    if (ptr == ptr_w'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + ptr_w'(1);
  endfunction

  // Push while full and pop while empty are dropped
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == cnt_w'(DEPTH));
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (do_pop)  rd_ptr_q <= next_ptr(rd_ptr_q);
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + cnt_w'(1);
        2'b01:   count_q <= count_q - cnt_w'(1);
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/uart_pkg.sv
/*
 * Types shared across the UART block: data byte,
 * receive FIFO entry and host status levels
 */

`default_nettype none

package uart_pkg;

  // One byte on the serial line
  typedef logic [7:0] uart_byte_t;

  // Receive FIFO payload, the byte plus its stop-bit check
  typedef struct packed {
    logic       frame_err;
    uart_byte_t data;
  } rx_entry_t;

  // Host-visible status levels
  typedef struct packed {
    logic tx_full;
    logic tx_busy;
    logic rx_valid;
    logic rx_overrun;
  } uart_status_t;

endpackage

`default_nettype wire

// File: include/uart_defines.svh
/*
 * Build constants for the UART block: system clock frequency,
 * serial bit rate, oversample ratio and FIFO depth
 */

`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// System clock in Hz
`define UART_CLK_FREQ 32_000_000

// Serial bit rate in bits per second
`define UART_BAUD_RATE 1_000_000

// Baud ticks per serial bit, the receiver samples mid-bit at tick 8
`define UART_OVERSAMPLE 16

// Entries held by each of the transmit and receive FIFOs
`define UART_FIFO_DEPTH 4

`endif
